// ==== rtl/trap_pkg.sv ====
// Trap unit shared definitions
`default_nettype none

package trap_pkg;

  localparam int xlen    = 64;
  localparam int excp_w  = 12;
  localparam int itrp_w  = 3;
  localparam int cause_w = 6;

  // exception line positions in excp_info
  localparam int excp_inst_misal = 0;
  localparam int excp_inst_acc   = 1;
  localparam int excp_ilg_inst   = 2;
  localparam int excp_brk_pt     = 3;
  localparam int excp_load_misal = 4;
  localparam int excp_load_acc   = 5;
  localparam int excp_stor_misal = 6;
  localparam int excp_stor_acc   = 7;
  localparam int excp_ecall_m    = 8;
  localparam int excp_inst_page  = 9;
  localparam int excp_load_page  = 10;
  localparam int excp_stor_page  = 11;

  // interrupt line positions in itrp_info
  localparam int itrp_soft  = 0;
  localparam int itrp_timer = 1;
  localparam int itrp_exter = 2;

  // mcause codes, privileged spec values
  localparam logic [cause_w-1:0] cause_inst_misal = 6'd0;
  localparam logic [cause_w-1:0] cause_inst_acc   = 6'd1;
  localparam logic [cause_w-1:0] cause_ilg_inst   = 6'd2;
  localparam logic [cause_w-1:0] cause_brk_pt     = 6'd3;
  localparam logic [cause_w-1:0] cause_load_misal = 6'd4;
  localparam logic [cause_w-1:0] cause_load_acc   = 6'd5;
  localparam logic [cause_w-1:0] cause_stor_misal = 6'd6;
  localparam logic [cause_w-1:0] cause_stor_acc   = 6'd7;
  localparam logic [cause_w-1:0] cause_ecall_m    = 6'd11;
  localparam logic [cause_w-1:0] cause_inst_page  = 6'd12;
  localparam logic [cause_w-1:0] cause_load_page  = 6'd13;
  localparam logic [cause_w-1:0] cause_stor_page  = 6'd15;
  localparam logic [cause_w-1:0] cause_itrp_soft  = 6'd3;
  localparam logic [cause_w-1:0] cause_itrp_timer = 6'd7;
  localparam logic [cause_w-1:0] cause_itrp_exter = 6'd11;

  localparam logic [11:0] csr_mstatus = 12'h300;
  localparam logic [11:0] csr_mtvec   = 12'h305;
  localparam logic [11:0] csr_mepc    = 12'h341;
  localparam logic [11:0] csr_mcause  = 12'h342;
  localparam logic [11:0] csr_mtval   = 12'h343;

  localparam int mstatus_mie  = 3;
  localparam int mstatus_mpie = 7;

  localparam logic [1:0] mtvec_direct   = 2'd0;
  localparam logic [1:0] mtvec_vectored = 2'd1;

endpackage

`default_nettype wire

// ==== rtl/csr_trap_if.sv ====
// Trap side CSR bus
`timescale 1ns/1ns
`default_nettype none

interface csr_trap_if;
  import trap_pkg::*;

  logic            trap_we;   // mcause, mepc, mtval
  logic            status_we; // mstatus only
  logic [xlen-1:0] mcause_wdata;
  logic [xlen-1:0] mepc_wdata;
  logic [xlen-1:0] mtval_wdata;
  logic [xlen-1:0] mstatus_wdata;

  logic [xlen-1:0] mstatus_rdata;
  logic [xlen-1:0] mtvec_rdata;
  logic [xlen-1:0] mepc_rdata;

  modport ctrl (output trap_we, status_we, mcause_wdata, mepc_wdata, mtval_wdata,
                output mstatus_wdata, input mstatus_rdata);
  modport csr (input trap_we, status_we, mcause_wdata, mepc_wdata, mtval_wdata,
               input mstatus_wdata, output mstatus_rdata, mtvec_rdata, mepc_rdata);

endinterface

`default_nettype wire

// ==== rtl/trap_cause_encoder.sv ====
// Trap cause priority encoder
`timescale 1ns/1ns
`default_nettype none

module trap_cause_encoder (
  input  logic [trap_pkg::excp_w-1:0]  excp_info,
  input  logic [trap_pkg::itrp_w-1:0]  itrp_info, // already masked by MIE
  output logic                         cause_valid,
  output logic                         cause_itrp,
  output logic [trap_pkg::cause_w-1:0] cause_code
);
  import trap_pkg::*;

  logic excp_any;
  logic itrp_any;

  assign excp_any    = |excp_info;
  assign itrp_any    = |itrp_info;
  assign cause_valid = excp_any | itrp_any;
  assign cause_itrp  = itrp_any; // interrupts beat exceptions

  // first set line wins, so several lines still give one code
  always_comb begin
    cause_code = '0;
    if (itrp_any) begin
      if (itrp_info[itrp_exter])
        cause_code = cause_itrp_exter;
      else if (itrp_info[itrp_soft])
        cause_code = cause_itrp_soft;
      else
        cause_code = cause_itrp_timer;
    end else if (excp_any) begin
      if (excp_info[excp_inst_page])
        cause_code = cause_inst_page;
      else if (excp_info[excp_inst_acc])
        cause_code = cause_inst_acc;
      else if (excp_info[excp_ilg_inst])
        cause_code = cause_ilg_inst;
      else if (excp_info[excp_inst_misal])
        cause_code = cause_inst_misal;
      else if (excp_info[excp_brk_pt])
        cause_code = cause_brk_pt;
      else if (excp_info[excp_ecall_m])
        cause_code = cause_ecall_m;
      else if (excp_info[excp_stor_misal])
        cause_code = cause_stor_misal;
      else if (excp_info[excp_load_misal])
        cause_code = cause_load_misal;
      else if (excp_info[excp_stor_page])
        cause_code = cause_stor_page;
      else if (excp_info[excp_load_page])
        cause_code = cause_load_page;
      else if (excp_info[excp_stor_acc])
        cause_code = cause_stor_acc;
      else
        cause_code = cause_load_acc; // only line left
    end
  end

endmodule

`default_nettype wire

// ==== rtl/trap_ctrl.sv ====
// Trap entry and exit control
`timescale 1ns/1ns
`default_nettype none

module trap_ctrl (
  csr_trap_if.ctrl                      csr,
  input  logic [trap_pkg::excp_w-1:0]   excp_info,
  input  logic [trap_pkg::itrp_w-1:0]   itrp_info,
  input  logic [trap_pkg::xlen-1:0]     now_pc,
  input  logic [31:0]                   now_inst,
  input  logic [trap_pkg::xlen-1:0]     mem_addr,
  input  logic                          trap_exit,  // mret retiring
  input  logic                          cause_valid,
  input  logic                          cause_itrp,
  input  logic [trap_pkg::cause_w-1:0]  cause_code,
  output logic [trap_pkg::itrp_w-1:0]   itrp_masked,
  output logic                          take_trap,
  output logic                          take_exit,
  output logic                          vector_sel,
  output logic                          jmp_ena,
  output logic                          ex_flush,
  output logic [trap_pkg::xlen-1:0]     trap_cause
);
  import trap_pkg::*;

  logic            mie;
  logic            inst_fault;
  logic            mem_fault;
  logic [xlen-1:0] mtval_next;
  logic [xlen-1:0] mstatus_next;

  assign mie         = csr.mstatus_rdata[mstatus_mie];
  assign itrp_masked = itrp_info & {itrp_w{mie}};

  assign take_trap  = cause_valid;
  assign take_exit  = trap_exit & ~take_trap; // entry overrides mret
  assign vector_sel = take_trap & cause_itrp;
  assign jmp_ena    = take_trap | take_exit;
  assign ex_flush   = jmp_ena;
  assign trap_cause = take_trap ? csr.mcause_wdata : '0;

  assign inst_fault = excp_info[excp_inst_page] | excp_info[excp_inst_acc];
  assign mem_fault  = excp_info[excp_stor_misal] | excp_info[excp_load_misal]
                    | excp_info[excp_stor_page] | excp_info[excp_load_page]
                    | excp_info[excp_stor_acc] | excp_info[excp_load_acc];

  // fault classes sit in priority order, so the first class set holds the winner
  always_comb begin
    mtval_next = '0;
    if (cause_itrp)
      mtval_next = '0;
    else if (inst_fault)
      mtval_next = now_pc;
    else if (excp_info[excp_ilg_inst])
      mtval_next = {{(xlen-32){1'b0}}, now_inst};
    else if (excp_info[excp_inst_misal])
      mtval_next = now_pc;
    else if (excp_info[excp_brk_pt] | excp_info[excp_ecall_m])
      mtval_next = '0;
    else if (mem_fault)
      mtval_next = mem_addr;
  end

  always_comb begin
    mstatus_next = csr.mstatus_rdata;
    if (take_trap) begin
      mstatus_next[mstatus_mpie] = mie;
      mstatus_next[mstatus_mie]  = 1'b0;
    end else begin
      mstatus_next[mstatus_mie]  = csr.mstatus_rdata[mstatus_mpie];
      mstatus_next[mstatus_mpie] = 1'b1;
    end
  end

  assign csr.trap_we       = take_trap;
  assign csr.status_we     = take_trap | take_exit;
  assign csr.mcause_wdata  = {cause_itrp, {(xlen-1-cause_w){1'b0}}, cause_code};
  assign csr.mepc_wdata    = cause_itrp ? now_pc + 64'd4 : now_pc; // resume after irq
  assign csr.mtval_wdata   = mtval_next;
  assign csr.mstatus_wdata = mstatus_next;

endmodule

`default_nettype wire

// ==== rtl/trap_target_gen.sv ====
// Trap redirect target
`timescale 1ns/1ns
`default_nettype none

module trap_target_gen (
  input  logic                         take_trap,
  input  logic                         take_exit,
  input  logic                         vector_sel, // interrupt entry
  input  logic [trap_pkg::cause_w-1:0] cause_code,
  input  logic [trap_pkg::xlen-1:0]    mtvec,
  input  logic [trap_pkg::xlen-1:0]    mepc,
  output logic [trap_pkg::xlen-1:0]    jmp_pc
);
  import trap_pkg::*;

  logic [1:0]      mode;
  logic [xlen-1:0] base;
  logic [xlen-1:0] vec_pc;
  logic [xlen-1:0] enter_pc;

  assign mode   = mtvec[1:0];
  assign base   = {mtvec[xlen-1:2], 2'b00};
  assign vec_pc = base + {{(xlen-cause_w-2){1'b0}}, cause_code, 2'b00}; // base + 4*code

  always_comb begin
    case (mode)
      mtvec_direct:   enter_pc = base;
      mtvec_vectored: enter_pc = vector_sel ? vec_pc : base;
      default:        enter_pc = base; // reserved modes act as direct
    endcase
  end

  always_comb begin
    jmp_pc = '0;
    if (take_exit)
      jmp_pc = mepc;
    else if (take_trap)
      jmp_pc = enter_pc;
  end

endmodule

`default_nettype wire

// ==== rtl/trap_csr_file.sv ====
// Machine trap CSR file
`timescale 1ns/1ns
`default_nettype none

module trap_csr_file (
  input  logic                      clk,
  input  logic                      reset,
  csr_trap_if.csr                   csr,
  input  logic                      csr_we,    // software write
  input  logic [11:0]               csr_waddr,
  input  logic [trap_pkg::xlen-1:0] csr_wdata,
  input  logic [11:0]               csr_raddr,
  output logic [trap_pkg::xlen-1:0] csr_rdata
);
  import trap_pkg::*;

  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] mcause;
  logic [xlen-1:0] mtval;

  logic sw_mstatus;
  logic sw_mtvec;
  logic sw_mepc;
  logic sw_mcause;
  logic sw_mtval;

  assign sw_mstatus = csr_we && (csr_waddr == csr_mstatus);
  assign sw_mtvec   = csr_we && (csr_waddr == csr_mtvec);
  assign sw_mepc    = csr_we && (csr_waddr == csr_mepc);
  assign sw_mcause  = csr_we && (csr_waddr == csr_mcause);
  assign sw_mtval   = csr_we && (csr_waddr == csr_mtval);

  // trap side writes win over software
  always_ff @(posedge clk) begin
    if (reset) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
      mtval   <= '0;
    end else begin
      if (csr.status_we)
        mstatus <= csr.mstatus_wdata;
      else if (sw_mstatus)
        mstatus <= csr_wdata;

      if (sw_mtvec)
        mtvec <= csr_wdata;

      if (csr.trap_we) begin
        mepc   <= {csr.mepc_wdata[xlen-1:2], 2'b00};
        mcause <= csr.mcause_wdata;
        mtval  <= csr.mtval_wdata;
      end else begin
        if (sw_mepc)
          mepc <= {csr_wdata[xlen-1:2], 2'b00}; // pc is word aligned
        if (sw_mcause)
          mcause <= csr_wdata;
        if (sw_mtval)
          mtval <= csr_wdata;
      end
    end
  end

  assign csr.mstatus_rdata = mstatus;
  assign csr.mtvec_rdata   = mtvec;
  assign csr.mepc_rdata    = mepc;

  always_comb begin
    case (csr_raddr)
      csr_mstatus: csr_rdata = mstatus;
      csr_mtvec:   csr_rdata = mtvec;
      csr_mepc:    csr_rdata = mepc;
      csr_mcause:  csr_rdata = mcause;
      csr_mtval:   csr_rdata = mtval;
      default:     csr_rdata = '0; // unmapped
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/trap_unit.sv ====
// Machine mode trap unit
`timescale 1ns/1ns
`default_nettype none

module trap_unit (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [trap_pkg::excp_w-1:0]  excp_info,
  input  logic [trap_pkg::itrp_w-1:0]  itrp_info,
  input  logic [trap_pkg::xlen-1:0]    now_pc,
  input  logic [31:0]                  now_inst,
  input  logic [trap_pkg::xlen-1:0]    mem_addr,
  input  logic                         trap_exit,
  input  logic                         csr_we,
  input  logic [11:0]                  csr_waddr,
  input  logic [trap_pkg::xlen-1:0]    csr_wdata,
  input  logic [11:0]                  csr_raddr,
  output logic [trap_pkg::xlen-1:0]    csr_rdata,
  output logic                         trap_enter,
  output logic                         jmp_ena,
  output logic [trap_pkg::xlen-1:0]    jmp_pc,
  output logic                         ex_flush,
  output logic [trap_pkg::xlen-1:0]    trap_cause
);
  import trap_pkg::*;

  logic               cause_valid;
  logic               cause_itrp;
  logic [cause_w-1:0] cause_code;
  logic [itrp_w-1:0]  itrp_masked;
  logic               take_exit;
  logic               vector_sel;

  csr_trap_if csr_bus ();

  trap_cause_encoder enc_i (
    .excp_info(excp_info), .itrp_info(itrp_masked),
    .cause_valid(cause_valid), .cause_itrp(cause_itrp), .cause_code(cause_code)
  );

  trap_ctrl ctrl_i (
    .csr(csr_bus.ctrl), .excp_info(excp_info), .itrp_info(itrp_info),
    .now_pc(now_pc), .now_inst(now_inst), .mem_addr(mem_addr), .trap_exit(trap_exit),
    .cause_valid(cause_valid), .cause_itrp(cause_itrp), .cause_code(cause_code),
    .itrp_masked(itrp_masked), .take_trap(trap_enter), .take_exit(take_exit),
    .vector_sel(vector_sel), .jmp_ena(jmp_ena), .ex_flush(ex_flush),
    .trap_cause(trap_cause)
  );

  trap_target_gen target_i (
    .take_trap(trap_enter), .take_exit(take_exit), .vector_sel(vector_sel),
    .cause_code(cause_code), .mtvec(csr_bus.mtvec_rdata), .mepc(csr_bus.mepc_rdata),
    .jmp_pc(jmp_pc)
  );

  trap_csr_file csr_i (
    .clk(clk), .reset(reset), .csr(csr_bus.csr), .csr_we(csr_we),
    .csr_waddr(csr_waddr), .csr_wdata(csr_wdata), .csr_raddr(csr_raddr),
    .csr_rdata(csr_rdata)
  );

endmodule

`default_nettype wire

// ==== verif/trap_unit_assertions.sv ====
// Trap unit port assertions
`timescale 1ns/1ns
`default_nettype none

module trap_unit_assertions (
  input logic                        clk,
  input logic                        reset,
  input logic [trap_pkg::excp_w-1:0] excp_info,
  input logic [trap_pkg::itrp_w-1:0] itrp_info,
  input logic                        trap_exit,
  input logic                        trap_enter,
  input logic                        jmp_ena,
  input logic                        ex_flush
);
  int fail_count = 0;

  flush_with_jump: assert property (@(posedge clk) disable iff (reset) ex_flush == jmp_ena)
    else begin
      fail_count++;
      $error("ex_flush differs from jmp_ena");
    end

  enter_jumps: assert property (@(posedge clk) disable iff (reset) trap_enter |-> jmp_ena)
    else begin
      fail_count++;
      $error("trap entered without a redirect");
    end

  // quiet inputs, no redirect
  idle_no_jump: assert property (@(posedge clk) disable iff (reset)
    (excp_info == '0 && itrp_info == '0 && !trap_exit) |-> !jmp_ena)
    else begin
      fail_count++;
      $error("redirect raised with no line and no exit");
    end

endmodule

bind trap_unit trap_unit_assertions assert_i (
  .clk(clk), .reset(reset), .excp_info(excp_info), .itrp_info(itrp_info),
  .trap_exit(trap_exit), .trap_enter(trap_enter), .jmp_ena(jmp_ena), .ex_flush(ex_flush)
);

`default_nettype wire

// ==== verif/trap_unit_tb.sv ====
// Trap unit testbench
`timescale 1ns/1ns
`default_nettype none

module trap_unit_tb;
  import trap_pkg::*;

  typedef struct packed {
    logic            enter;
    logic [xlen-1:0] jpc;
    logic [xlen-1:0] cause;
    logic [xlen-1:0] mstatus;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    logic [xlen-1:0] mtval;
  } model_t;

  // exception lines in priority order, with cause code and mtval source
  // mtval source 0 zero, 1 pc, 2 instruction word, 3 memory address
  int prio_bit[12]  = '{excp_inst_page, excp_inst_acc, excp_ilg_inst, excp_inst_misal,
                        excp_brk_pt, excp_ecall_m, excp_stor_misal, excp_load_misal,
                        excp_stor_page, excp_load_page, excp_stor_acc, excp_load_acc};
  int prio_code[12] = '{12, 1, 2, 0, 3, 11, 6, 4, 15, 13, 7, 5};
  int prio_tval[12] = '{1, 1, 2, 1, 0, 0, 3, 3, 3, 3, 3, 3};
  logic [11:0] csr_list[6] = '{csr_mstatus, csr_mtvec, csr_mepc, csr_mcause, csr_mtval,
                               12'h344}; // last one unmapped
  int cycle_limit = 1500;
  int cycles = 0;

  logic              clk;
  logic              reset;
  logic [excp_w-1:0] excp_info;
  logic [itrp_w-1:0] itrp_info;
  logic [xlen-1:0]   now_pc;
  logic [31:0]       now_inst;
  logic [xlen-1:0]   mem_addr;
  logic              trap_exit;
  logic              csr_we;
  logic [11:0]       csr_waddr;
  logic [xlen-1:0]   csr_wdata;
  logic [11:0]       csr_raddr;
  logic [xlen-1:0]   csr_rdata;
  logic              trap_enter;
  logic              jmp_ena;
  logic [xlen-1:0]   jmp_pc;
  logic              ex_flush;
  logic [xlen-1:0]   trap_cause;
  model_t            st; // model copy of the CSRs

  trap_unit dut_i (
    .clk(clk), .reset(reset), .excp_info(excp_info), .itrp_info(itrp_info),
    .now_pc(now_pc), .now_inst(now_inst), .mem_addr(mem_addr), .trap_exit(trap_exit),
    .csr_we(csr_we), .csr_waddr(csr_waddr), .csr_wdata(csr_wdata), .csr_raddr(csr_raddr),
    .csr_rdata(csr_rdata), .trap_enter(trap_enter), .jmp_ena(jmp_ena), .jmp_pc(jmp_pc),
    .ex_flush(ex_flush), .trap_cause(trap_cause)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    abort_run("timeout, the tests did not finish within the cycle limit");
  end

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_val(string name, logic [xlen-1:0] got, logic [xlen-1:0] want);
    assert (got === want)
      else abort_run($sformatf("ERROR: %s is 0x%0h, expected 0x%0h", name, got, want));
  endtask

  function automatic model_t ref_step(model_t s);
    model_t     n;
    logic [2:0] irq;
    logic       hit;
    int         code;
    int         tval;
    n       = s;
    n.enter = 1'b0;
    n.jpc   = '0;
    n.cause = '0;
    irq  = itrp_info & {3{s.mstatus[mstatus_mie]}};
    hit  = (|irq) || (|excp_info);
    code = 0;
    tval = 0;
    for (int i = 11; i >= 0; i--) begin // highest priority visited last
      if (excp_info[prio_bit[i]]) begin
        code = prio_code[i];
        tval = prio_tval[i];
      end
    end
    if (|irq) begin
      code = irq[itrp_exter] ? 11 : (irq[itrp_soft] ? 3 : 7);
      tval = 0;
    end
    if (csr_we) begin
      case (csr_waddr)
        csr_mstatus: n.mstatus = csr_wdata;
        csr_mtvec:   n.mtvec = csr_wdata;
        csr_mepc:    n.mepc = {csr_wdata[xlen-1:2], 2'b00};
        csr_mcause:  n.mcause = csr_wdata;
        csr_mtval:   n.mtval = csr_wdata;
        default:     ;
      endcase
    end
    if (hit) begin
      n.enter  = 1'b1;
      n.cause  = {|irq, {(xlen-7){1'b0}}, code[5:0]};
      n.mcause = n.cause;
      n.mepc   = {now_pc[xlen-1:2], 2'b00} + ((|irq) ? 64'd4 : 64'd0);
      case (tval)
        1:       n.mtval = now_pc;
        2:       n.mtval = {32'b0, now_inst};
        3:       n.mtval = mem_addr;
        default: n.mtval = '0;
      endcase
      n.mstatus               = s.mstatus;
      n.mstatus[mstatus_mpie] = s.mstatus[mstatus_mie];
      n.mstatus[mstatus_mie]  = 1'b0;
      n.jpc = {s.mtvec[xlen-1:2], 2'b00};
      if (s.mtvec[1:0] == mtvec_vectored && (|irq))
        n.jpc = n.jpc + 64'(4 * code);
    end else if (trap_exit) begin
      n.jpc                   = s.mepc;
      n.mstatus               = s.mstatus;
      n.mstatus[mstatus_mie]  = s.mstatus[mstatus_mpie];
      n.mstatus[mstatus_mpie] = 1'b1;
    end
    return n;
  endfunction

  function automatic logic [xlen-1:0] read_csr(model_t s, logic [11:0] addr);
    case (addr)
      csr_mstatus: return s.mstatus;
      csr_mtvec:   return s.mtvec;
      csr_mepc:    return s.mepc;
      csr_mcause:  return s.mcause;
      csr_mtval:   return s.mtval;
      default:     return '0;
    endcase
  endfunction

  initial begin
    model_t want;
    st = '0;
    forever begin
      @(posedge clk);
      #39; // one unit before the next edge
      if (reset) begin
        st = '0;
      end else begin
        want = ref_step(st);
        check_val("trap_enter", 64'(trap_enter), 64'(want.enter));
        check_val("jmp_ena", 64'(jmp_ena), 64'(want.enter | trap_exit));
        check_val("ex_flush", 64'(ex_flush), 64'(want.enter | trap_exit));
        check_val("jmp_pc", jmp_pc, want.jpc);
        check_val("trap_cause", trap_cause, want.cause);
        check_val("csr_rdata", csr_rdata, read_csr(st, csr_raddr));
        assert (dut_i.assert_i.fail_count == 0)
          else abort_run("a bound assertion on the trap unit ports failed");
        st = want;
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    excp_info <= '0;
    itrp_info <= '0;
    trap_exit <= 1'b0;
    csr_we    <= 1'b0;
  endtask

  task automatic sw_write(logic [11:0] addr, logic [xlen-1:0] data);
    next_cycle();
    csr_we    <= 1'b1;
    csr_waddr <= addr;
    csr_wdata <= data;
    next_cycle();
    csr_raddr <= addr; // read back
  endtask

  task automatic read_trap_csrs();
    for (int k = 2; k < 5; k++) begin // mepc, mcause, mtval
      next_cycle();
      csr_raddr <= csr_list[k];
    end
  endtask

  initial begin
    int sel;
    void'($urandom(49));
    reset     = 1'b1;
    excp_info = '0;
    itrp_info = '0;
    now_pc    = 64'h8000_0000;
    now_inst  = '0;
    mem_addr  = '0;
    trap_exit = 1'b0;
    csr_we    = 1'b0;
    csr_waddr = '0;
    csr_wdata = '0;
    csr_raddr = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // reset values, then software write and read back
    for (int k = 0; k < 6; k++) begin
      next_cycle();
      csr_raddr <= csr_list[k];
    end
    for (int k = 0; k < 6; k++)
      sw_write(csr_list[k], {$urandom, $urandom});
    sw_write(csr_mstatus, '0);
    sw_write(csr_mtvec, 64'h8000_0100);

    for (int i = 0; i < excp_w; i++) begin // each exception alone
      next_cycle();
      excp_info[i] <= 1'b1;
      now_pc       <= {$urandom, $urandom} & ~64'h3;
      now_inst     <= $urandom;
      mem_addr     <= {$urandom, $urandom};
      read_trap_csrs();
    end

    // interrupts masked, then taken in vectored and direct mode
    for (int i = 0; i < itrp_w; i++) begin
      next_cycle();
      itrp_info[i] <= 1'b1;
    end
    for (int m = 1; m >= 0; m--) begin
      sw_write(csr_mtvec, 64'h8000_0100 | 64'(m));
      for (int i = 0; i < itrp_w; i++) begin
        sw_write(csr_mstatus, 64'h8);
        next_cycle();
        itrp_info[i] <= 1'b1;
        read_trap_csrs();
      end
    end

    // several lines at once, third pass is illegal over inst misaligned
    for (int n = 0; n < 12; n++) begin
      sw_write(csr_mstatus, 64'h8);
      next_cycle();
      excp_info <= (n < 2) ? 12'hfff : ((n == 2) ? 12'h005 : 12'($urandom));
      itrp_info <= (n == 1) ? 3'b111 : ((n < 3) ? 3'b000 : 3'($urandom));
      read_trap_csrs();
    end

    // mret, then mret against a trap and a software mepc write
    sw_write(csr_mepc, 64'h8000_1237);
    sw_write(csr_mstatus, 64'h80);
    next_cycle();
    trap_exit <= 1'b1;
    next_cycle();
    csr_raddr <= csr_mstatus;
    next_cycle();
    trap_exit               <= 1'b1;
    excp_info[excp_ecall_m] <= 1'b1;
    csr_we                  <= 1'b1;
    csr_waddr               <= csr_mepc;
    csr_wdata               <= 64'h1000;
    read_trap_csrs();

    repeat (400) begin
      next_cycle();
      if ($urandom % 4 == 0)
        excp_info <= 12'($urandom) & 12'($urandom) & 12'($urandom);
      if ($urandom % 3 == 0)
        itrp_info <= 3'($urandom);
      trap_exit <= ($urandom % 6 == 0);
      if ($urandom % 4 == 0) begin
        sel = $urandom_range(5, 0);
        csr_we    <= 1'b1;
        csr_waddr <= csr_list[sel];
        csr_wdata <= {$urandom, $urandom};
      end
      sel = $urandom_range(5, 0);
      csr_raddr <= csr_list[sel];
      now_pc    <= {$urandom, $urandom};
      now_inst  <= $urandom;
      mem_addr  <= {$urandom, $urandom};
    end

    next_cycle();
    @(posedge clk);
    #1;
    if (dut_i.assert_i.fail_count == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      abort_run("a bound assertion on the trap unit ports failed");
    end
  end

endmodule

`default_nettype wire

// ==== trap_unit.f ====
rtl/trap_pkg.sv
rtl/csr_trap_if.sv
rtl/trap_cause_encoder.sv
rtl/trap_ctrl.sv
rtl/trap_target_gen.sv
rtl/trap_csr_file.sv
rtl/trap_unit.sv
verif/trap_unit_assertions.sv
verif/trap_unit_tb.sv
